//--- design/cpu_pkg.sv
package cpu_pkg;

    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    // 3R and shift-immediate groups share inst[31:20], minor in inst[19:15]
    localparam logic [11:0] maj_3r     = 12'h001;
    localparam logic [11:0] maj_shift  = 12'h004;
    localparam logic [4:0]  min_add_w  = 5'h00;
    localparam logic [4:0]  min_sub_w  = 5'h02;
    localparam logic [4:0]  min_slt    = 5'h04;
    localparam logic [4:0]  min_sltu   = 5'h05;
    localparam logic [4:0]  min_nor    = 5'h08;
    localparam logic [4:0]  min_and    = 5'h09;
    localparam logic [4:0]  min_or     = 5'h0a;
    localparam logic [4:0]  min_xor    = 5'h0b;
    localparam logic [4:0]  min_slli_w = 5'h01;
    localparam logic [4:0]  min_srli_w = 5'h09;
    localparam logic [4:0]  min_srai_w = 5'h11;
    localparam logic [9:0]  op_addi_w  = 10'h00a;     // inst[31:22]
    localparam logic [9:0]  op_ld_w    = 10'h0a2;
    localparam logic [9:0]  op_st_w    = 10'h0a6;
    localparam logic [6:0]  op_lu12i_w = 7'h0a;       // inst[31:25]
    localparam logic [5:0]  op_jirl    = 6'h13;       // inst[31:26]
    localparam logic [5:0]  op_b       = 6'h14;
    localparam logic [5:0]  op_bl      = 6'h15;
    localparam logic [5:0]  op_beq     = 6'h16;
    localparam logic [5:0]  op_bne     = 6'h17;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_jump, br_jirl
    } br_kind_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fd_payload_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rj_val;
        logic [31:0] rkd_val;
        logic [31:0] imm;
        logic [31:0] br_offs;
        alu_op_e     alu_op;
        logic        src1_is_pc;
        logic        src2_is_imm;
        br_kind_e    br_kind;
        logic        mem_we;
        logic        res_from_mem;
        logic        gr_we;
        logic [4:0]  dest;
    } de_payload_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic        res_from_mem;
        logic        gr_we;
        logic [4:0]  dest;
    } em_payload_t;

endpackage

//--- design/stage_link.sv
`timescale 1ns/1ns

interface stage_link #(
    parameter type payload_t = logic
) ();
    logic     valid;
    logic     ready;
    payload_t payload;     // Held steady from valid until the transfer

    modport master (
        output valid,
        output payload,
        input  ready
    );

    modport slave (
        input  valid,
        input  payload,
        output ready
    );
endinterface

//--- design/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    stage_link.master   out
);
    import cpu_pkg::*;

    logic [31:0] pc;
    logic [31:0] pend_pc;
    logic        pend_valid;
    logic        issue;

    assign issue          = !pend_valid || out.ready;
    assign inst_sram_addr = issue ? pc : pend_pc;      // Re-read while decode stalls

    assign out.valid        = pend_valid;
    assign out.payload.pc   = pend_pc;
    assign out.payload.inst = inst_sram_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= reset_pc;
            pend_valid <= 1'b0;
        end else if (redirect_valid) begin
            pc         <= redirect_pc;
            pend_valid <= 1'b0;                         // Word in flight is stale
        end else if (issue) begin
            pc         <= pc + 32'd4;
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue)
            pend_pc <= pc;
    end

    // Holding the word relies on the SRAM returning the same data for the same address
    payload_hold: assert property (@(posedge clk) disable iff (reset)
        out.valid && !out.ready && !redirect_valid |=> $stable(out.payload));

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);
    logic [31:0] regs [31:0];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0)
            regs[waddr] <= wdata;
    end

    // Write-through so a released register reads its new value
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic        clk,
    input  logic        reset,
    stage_link.slave    in,
    stage_link.master   out,
    input  logic        redirect_valid,
    input  logic        wb_we,
    input  logic [4:0]  wb_waddr,
    input  logic [31:0] wb_wdata
);
    import cpu_pkg::*;

    logic [31:0] inst, imm, br_offs, rj_val, rkd_val;
    logic [31:0] busy, busy_eff, set_mask;
    logic [4:0]  rd, rj, rk, src2, dest;
    logic        is_3r, is_shift, is_addi, is_ld, is_st, is_lu12i;
    logic        is_jirl, is_b, is_bl, is_beq, is_bne, link;
    logic        use_rj, use_rkd, src2_is_imm, gr_we, stall, fire;
    alu_op_e     alu_op;
    br_kind_e    br_kind;

    assign inst = in.payload.inst;
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];

    assign is_3r    = inst[31:20] == maj_3r;
    assign is_shift = inst[31:20] == maj_shift;
    assign is_addi  = inst[31:22] == op_addi_w;
    assign is_ld    = inst[31:22] == op_ld_w;
    assign is_st    = inst[31:22] == op_st_w;
    assign is_lu12i = inst[31:25] == op_lu12i_w;
    assign is_jirl  = inst[31:26] == op_jirl;
    assign is_b     = inst[31:26] == op_b;
    assign is_bl    = inst[31:26] == op_bl;
    assign is_beq   = inst[31:26] == op_beq;
    assign is_bne   = inst[31:26] == op_bne;

    assign link        = is_jirl || is_bl;                 // Writes pc+4
    assign use_rj      = !(is_lu12i || is_b || is_bl);
    assign use_rkd     = is_3r || is_st || is_beq || is_bne;
    assign src2        = (is_st || is_beq || is_bne) ? rd : rk;
    assign src2_is_imm = is_shift || is_addi || is_ld || is_st || is_lu12i || link;
    assign gr_we       = is_3r || is_shift || is_addi || is_ld || is_lu12i || link;
    assign dest        = is_bl ? 5'd1 : rd;

    assign imm = link     ? 32'd4 :
                 is_lu12i ? {inst[24:5], 12'd0} :
                 is_shift ? {27'd0, inst[14:10]} :
                            {{20{inst[21]}}, inst[21:10]};
    assign br_offs = (is_b || is_bl) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00} :
                                       {{14{inst[25]}}, inst[25:10], 2'b00};
    assign br_kind = is_beq ? br_beq : is_bne ? br_bne : is_jirl ? br_jirl :
                     (is_b || is_bl) ? br_jump : br_none;

    always_comb begin
        alu_op = alu_add;
        if (is_lu12i) begin
            alu_op = alu_lui;
        end else if (is_3r) begin
            case (inst[19:15])
                min_add_w: alu_op = alu_add;
                min_sub_w: alu_op = alu_sub;
                min_slt:   alu_op = alu_slt;
                min_sltu:  alu_op = alu_sltu;
                min_nor:   alu_op = alu_nor;
                min_and:   alu_op = alu_and;
                min_or:    alu_op = alu_or;
                min_xor:   alu_op = alu_xor;
                default:   alu_op = alu_add;
            endcase
        end else if (is_shift) begin
            case (inst[19:15])
                min_slli_w: alu_op = alu_sll;
                min_srli_w: alu_op = alu_srl;
                min_srai_w: alu_op = alu_sra;
                default:    alu_op = alu_add;
            endcase
        end
    end

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (src2),
        .rdata1 (rj_val),
        .rdata2 (rkd_val),
        .we     (wb_we),
        .waddr  (wb_waddr),
        .wdata  (wb_wdata)
    );

    // Scoreboard, released on the write-back edge
    assign busy_eff = busy & ~(wb_we ? 32'd1 << wb_waddr : 32'd0);
    assign stall    = (use_rj && busy_eff[rj]) || (use_rkd && busy_eff[src2])
                   || (gr_we && busy_eff[dest]);
    assign in.ready = !stall && (!out.valid || out.ready);
    assign fire     = in.valid && in.ready && !redirect_valid;
    assign set_mask = (fire && gr_we && dest != 5'd0) ? 32'd1 << dest : 32'd0;

    always_ff @(posedge clk) begin
        if (reset)
            busy <= 32'd0;
        else
            busy <= busy_eff | set_mask;
    end

    always_ff @(posedge clk) begin
        if (reset)
            out.valid <= 1'b0;
        else if (redirect_valid || !out.valid || out.ready)
            out.valid <= fire;                              // Drops the slot on a redirect
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out.payload.pc           <= in.payload.pc;
            out.payload.rj_val       <= rj_val;
            out.payload.rkd_val      <= rkd_val;
            out.payload.imm          <= imm;
            out.payload.br_offs      <= br_offs;
            out.payload.alu_op       <= alu_op;
            out.payload.src1_is_pc   <= link;
            out.payload.src2_is_imm  <= src2_is_imm;
            out.payload.br_kind      <= br_kind;
            out.payload.mem_we       <= is_st;
            out.payload.res_from_mem <= is_ld;
            out.payload.gr_we        <= gr_we;
            out.payload.dest         <= dest;
        end
    end

    // Nothing passes while the packet in execute still owes one of its sources
    sources_free: assert property (@(posedge clk) disable iff (reset)
        fire && out.valid && out.payload.gr_we && out.payload.dest != 5'd0
        |-> !(use_rj && out.payload.dest == rj) && !(use_rkd && out.payload.dest == src2));

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic        clk,
    input  logic        reset,
    stage_link.slave    in,
    stage_link.master   out,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata
);
    import cpu_pkg::*;

    de_payload_t d;
    logic [31:0] src1, src2, alu_result, wdata_q;
    logic        fire, taken, mem_we_q;

    assign d        = in.payload;
    assign in.ready = !out.valid || out.ready;
    assign fire     = in.valid && in.ready;
    assign src1     = d.src1_is_pc ? d.pc : d.rj_val;
    assign src2     = d.src2_is_imm ? d.imm : d.rkd_val;

    always_comb begin
        case (d.alu_op)
            alu_add:  alu_result = src1 + src2;
            alu_sub:  alu_result = src1 - src2;
            alu_slt:  alu_result = {31'd0, $signed(src1) < $signed(src2)};
            alu_sltu: alu_result = {31'd0, src1 < src2};
            alu_and:  alu_result = src1 & src2;
            alu_nor:  alu_result = ~(src1 | src2);
            alu_or:   alu_result = src1 | src2;
            alu_xor:  alu_result = src1 ^ src2;
            alu_sll:  alu_result = src1 << src2[4:0];
            alu_srl:  alu_result = src1 >> src2[4:0];
            alu_sra:  alu_result = $signed(src1) >>> src2[4:0];
            alu_lui:  alu_result = src2;                    // Immediate already shifted
            default:  alu_result = 32'd0;
        endcase
    end

    always_comb begin
        case (d.br_kind)
            br_beq:           taken = d.rj_val == d.rkd_val;
            br_bne:           taken = d.rj_val != d.rkd_val;
            br_jump, br_jirl: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign redirect_valid = fire && taken;
    assign redirect_pc    = (d.br_kind == br_jirl ? d.rj_val : d.pc) + d.br_offs;

    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid <= 1'b0;
            mem_we_q  <= 1'b0;
        end else if (in.ready) begin
            out.valid <= in.valid;
            mem_we_q  <= fire && d.mem_we;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out.payload.pc           <= d.pc;
            out.payload.result       <= alu_result;
            out.payload.res_from_mem <= d.res_from_mem;
            out.payload.gr_we        <= d.gr_we;
            out.payload.dest         <= d.dest;
            wdata_q                  <= d.rkd_val;
        end
    end

    // Address goes out with the packet so load data meets it in write-back
    assign data_sram_we    = mem_we_q && out.valid && out.ready;
    assign data_sram_addr  = out.payload.result;
    assign data_sram_wdata = wdata_q;

    // A store in the shadow of a taken branch never reaches the SRAM
    shadow_store: assert property (@(posedge clk) disable iff (reset)
        $past(redirect_valid) |=> !data_sram_we);

endmodule

//--- design/mem_wb_stage.sv
`timescale 1ns/1ns

module mem_wb_stage (
    input  logic        clk,
    input  logic        reset,
    stage_link.slave    in,
    input  logic [31:0] data_sram_rdata,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    em_payload_t em_q;
    logic        valid_q;

    assign in.ready = 1'b1;                                 // Write-back never stalls

    always_ff @(posedge clk) begin
        if (reset)
            valid_q <= 1'b0;
        else
            valid_q <= in.valid;
    end

    always_ff @(posedge clk) begin
        if (in.valid)
            em_q <= in.payload;
    end

    assign rf_we    = valid_q && em_q.gr_we;
    assign rf_waddr = em_q.dest;
    assign rf_wdata = em_q.res_from_mem ? data_sram_rdata : em_q.result;

    // r0 writes are discarded, so the trace hides them
    assign debug_wb_pc       = em_q.pc;
    assign debug_wb_rf_we    = {4{rf_we && em_q.dest != 5'd0}};
    assign debug_wb_rf_wnum  = em_q.dest;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

//--- design/cpu_top.sv
`timescale 1ns/1ns

module cpu_top (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    stage_link #(.payload_t(fd_payload_t)) fd_link ();
    stage_link #(.payload_t(de_payload_t)) de_link ();
    stage_link #(.payload_t(em_payload_t)) em_link ();

    fetch_stage u_fetch (
        .clk             (clk),
        .reset           (reset),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .out             (fd_link.master)
    );

    decode_stage u_decode (
        .clk            (clk),
        .reset          (reset),
        .in             (fd_link.slave),
        .out            (de_link.master),
        .redirect_valid (redirect_valid),
        .wb_we          (rf_we),
        .wb_waddr       (rf_waddr),
        .wb_wdata       (rf_wdata)
    );

    execute_stage u_execute (
        .clk             (clk),
        .reset           (reset),
        .in              (de_link.slave),
        .out             (em_link.master),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    mem_wb_stage u_mem_wb (
        .clk               (clk),
        .reset             (reset),
        .in                (em_link.slave),
        .data_sram_rdata   (data_sram_rdata),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

//--- tb/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

localparam int          mem_words = 1024;
localparam logic [31:0] self_loop = {op_b, 26'd0};    // b 0

logic [31:0] prog [$];
logic [31:0] ref_dmem [0:mem_words-1];
logic [31:0] exp_pc [$];
logic [4:0]  exp_num [$];
logic [31:0] exp_val [$];

function automatic logic [31:0] enc_3r(logic [4:0] minor, logic [4:0] rd, logic [4:0] rj,
                                       logic [4:0] rk);
    return {maj_3r, minor, rk, rj, rd};
endfunction

function automatic logic [31:0] enc_shift(logic [4:0] minor, logic [4:0] rd, logic [4:0] rj,
                                          logic [4:0] ui5);
    return {maj_shift, minor, ui5, rj, rd};
endfunction

function automatic logic [31:0] enc_ri12(logic [9:0] op, logic [4:0] rd, logic [4:0] rj,
                                         logic [11:0] si12);
    return {op, si12, rj, rd};
endfunction

function automatic logic [31:0] enc_lu12i(logic [4:0] rd, logic [19:0] si20);
    return {op_lu12i_w, si20, rd};
endfunction

function automatic logic [31:0] enc_br(logic [5:0] op, logic [4:0] rj, logic [4:0] rd,
                                       logic [15:0] offs);
    return {op, offs, rj, rd};                          // Offset in words
endfunction

function automatic logic [31:0] enc_jump(logic [5:0] op, logic [25:0] offs);
    return {op, offs[15:0], offs[25:16]};
endfunction

function automatic logic [31:0] dmem_fill(int i);
    return (i * 32'h0001_9e37) ^ 32'hc3a5_0f0f;
endfunction

// Instruction-level run of prog, fills the expected write list
function automatic void run_reference();
    logic [31:0] regs [0:31];
    logic [31:0] pc, inst, a, res, next_pc, imm12, offs16, offs26, addr;
    logic [4:0]  rd, rj, rk;
    logic        wr;
    int          idx;
    for (idx = 0; idx < 32; idx++)
        regs[idx] = 32'd0;
    exp_pc.delete();
    exp_num.delete();
    exp_val.delete();
    pc = reset_pc;
    for (int step = 0; step < 4000; step++) begin
        idx  = (pc - reset_pc) >> 2;
        inst = (idx < prog.size()) ? prog[idx] : self_loop;
        if (inst == self_loop)
            break;
        rd      = inst[4:0];
        rj      = inst[9:5];
        rk      = inst[14:10];
        a       = regs[rj];
        imm12   = {{20{inst[21]}}, inst[21:10]};
        offs16  = {{14{inst[25]}}, inst[25:10], 2'b00};
        offs26  = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        addr    = a + imm12;
        next_pc = pc + 32'd4;
        wr      = 1'b1;
        res     = 32'd0;
        if (inst[31:20] == maj_3r) begin
            case (inst[19:15])
                min_add_w: res = a + regs[rk];
                min_sub_w: res = a - regs[rk];
                min_slt:   res = ($signed(a) < $signed(regs[rk])) ? 32'd1 : 32'd0;
                min_sltu:  res = (a < regs[rk]) ? 32'd1 : 32'd0;
                min_nor:   res = ~(a | regs[rk]);
                min_and:   res = a & regs[rk];
                min_or:    res = a | regs[rk];
                min_xor:   res = a ^ regs[rk];
                default:   wr = 1'b0;
            endcase
        end else if (inst[31:20] == maj_shift) begin
            case (inst[19:15])
                min_slli_w: res = a << rk;
                min_srli_w: res = a >> rk;
                min_srai_w: res = $signed(a) >>> rk;
                default:    wr = 1'b0;
            endcase
        end else if (inst[31:22] == op_addi_w) begin
            res = addr;
        end else if (inst[31:22] == op_ld_w) begin
            res = ref_dmem[addr[11:2]];
        end else if (inst[31:22] == op_st_w) begin
            ref_dmem[addr[11:2]] = regs[rd];
            wr = 1'b0;
        end else if (inst[31:25] == op_lu12i_w) begin
            res = {inst[24:5], 12'd0};
        end else if (inst[31:26] == op_jirl) begin
            res     = pc + 32'd4;
            next_pc = a + offs16;                        // rj read before rd is written
        end else if (inst[31:26] == op_b || inst[31:26] == op_bl) begin
            next_pc = pc + offs26;
            wr      = inst[31:26] == op_bl;
            rd      = 5'd1;
            res     = pc + 32'd4;
        end else begin
            wr = 1'b0;
            if ((inst[31:26] == op_beq && a == regs[rd]) ||
                (inst[31:26] == op_bne && a != regs[rd]))
                next_pc = pc + offs16;
        end
        if (wr && rd != 5'd0) begin
            regs[rd] = res;
            exp_pc.push_back(pc);
            exp_num.push_back(rd);
            exp_val.push_back(res);
        end
        pc = next_pc;
    end
endfunction

`endif

//--- tb/tb_cpu_top.sv
`timescale 1ns/1ns

module tb_cpu_top;
    import cpu_pkg::*;

    `include "cpu_ref_model.svh"

    logic        clk, reset;
    logic [31:0] inst_sram_addr, inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr, data_sram_wdata, data_sram_rdata;
    logic [31:0] debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] imem [0:mem_words-1];
    logic [31:0] dmem [0:mem_words-1];
    logic [31:0] inst_addr_q, data_addr_q;
    int          got, test_errors, total_errors, failed_tests, test_count;

    cpu_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Synchronous SRAM models, data out on the falling edge
    always @(posedge clk) begin
        inst_addr_q <= inst_sram_addr;
        data_addr_q <= data_sram_addr;
        if (data_sram_we)
            dmem[data_sram_addr[11:2]] <= data_sram_wdata;
    end

    always @(negedge clk) begin
        inst_sram_rdata <= imem[inst_addr_q[11:2]];
        data_sram_rdata <= dmem[data_addr_q[11:2]];
    end

    // Trace compare
    always @(posedge clk) begin
        if (!reset && debug_wb_rf_we != 4'd0) begin
            assert (got < exp_pc.size()) else begin
                $display("error @%0t: unexpected write pc %h r%0d", $time, debug_wb_pc,
                         debug_wb_rf_wnum);
                test_errors++;
            end
            if (got < exp_pc.size()) begin
                assert (debug_wb_pc == exp_pc[got] && debug_wb_rf_wnum == exp_num[got]
                        && debug_wb_rf_wdata == exp_val[got]) else begin
                    $display("error @%0t: got pc %h r%0d=%h, expected pc %h r%0d=%h", $time,
                             debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                             exp_pc[got], exp_num[got], exp_val[got]);
                    test_errors++;
                end
            end
            got++;
        end
    end

    function automatic logic [4:0] dest_reg();
        return 5'd4 + 5'($urandom % 8);                     // r4..r11
    endfunction

    function automatic logic [4:0] src_reg();
        int r;
        r = $urandom % 9;
        return (r == 8) ? 5'd0 : 5'd4 + 5'(r);
    endfunction

    task automatic run_test(input string name);
        int cycles;
        reset = 1'b1;
        got   = 0;
        for (int i = 0; i < mem_words; i++) begin
            imem[i]     = (i < prog.size()) ? prog[i] : self_loop;
            dmem[i]     = dmem_fill(i);
            ref_dmem[i] = dmem[i];
        end
        run_reference();
        repeat (2) begin
            @(negedge clk);
            assert (debug_wb_rf_we == 4'd0 && data_sram_we == 1'b0) else begin
                $display("a write enable was high during reset in test %s", name);
                test_errors++;
            end
        end
        reset = 1'b0;
        assert (inst_sram_addr == 32'h1c00_0000) else begin
            $display("error @%0t: first fetch address %h, expected %h", $time,
                     inst_sram_addr, 32'h1c00_0000);
            test_errors++;
        end
        cycles = 0;
        while (got < exp_pc.size() && cycles < 3000) begin
            @(negedge clk);
            cycles++;
        end
        repeat (8) @(negedge clk);                          // Room for a stray late write
        if (got < exp_pc.size()) begin
            $display("trace stalled in test %s after %0d of %0d writes", name, got,
                     exp_pc.size());
            test_errors++;
        end
        for (int i = 0; i < mem_words; i++) begin
            assert (dmem[i] === ref_dmem[i]) else begin
                $display("error @%0t: data word %0d is %h, expected %h", $time, i, dmem[i],
                         ref_dmem[i]);
                test_errors++;
            end
        end
        $display("test %s %s, %0d writes, %0d errors", name,
                 (test_errors == 0) ? "passed" : "failed", got, test_errors);
        test_count++;
        total_errors += test_errors;
        if (test_errors != 0)
            failed_tests++;
        test_errors = 0;
    endtask

    task automatic seed_regs(input int first, input int last);
        for (int r = first; r <= last; r++) begin
            prog.push_back(enc_lu12i(5'(r), $urandom));
            prog.push_back(enc_ri12(op_addi_w, 5'(r), 5'(r), $urandom));
        end
    endtask

    task automatic build_alu();
        logic [4:0] minors [8];
        minors = '{min_add_w, min_sub_w, min_slt, min_sltu, min_nor, min_and, min_or, min_xor};
        prog.delete();
        seed_regs(4, 11);
        for (int i = 0; i < 40; i++)
            prog.push_back(enc_3r(minors[$urandom % 8], dest_reg(), src_reg(), src_reg()));
        prog.push_back(self_loop);
    endtask

    task automatic build_shift();
        logic [4:0] minors [3];
        minors = '{min_slli_w, min_srli_w, min_srai_w};
        prog.delete();
        seed_regs(4, 11);
        for (int i = 0; i < 16; i++)
            prog.push_back(enc_shift(minors[$urandom % 3], dest_reg(), src_reg(), $urandom));
        for (int i = 0; i < 4; i++) begin
            prog.push_back(enc_ri12(op_addi_w, dest_reg(), src_reg(), 12'h800 | $urandom));
            prog.push_back(enc_lu12i(dest_reg(), $urandom));
        end
        prog.push_back(self_loop);
    endtask

    task automatic build_mem();
        logic [11:0] offs;
        prog.delete();
        prog.push_back(enc_ri12(op_addi_w, 5'd12, 5'd0, 12'h100));     // Base address
        for (int i = 0; i < 8; i++) begin
            offs = 12'(($urandom % 128) * 4);
            prog.push_back(enc_lu12i(5'd13, $urandom));
            prog.push_back(enc_ri12(op_addi_w, 5'd13, 5'd13, $urandom));
            prog.push_back(enc_ri12(op_st_w, 5'd13, 5'd12, offs));
            prog.push_back(enc_ri12(op_ld_w, 5'd14, 5'd12, offs));
            prog.push_back(enc_ri12(op_ld_w, 5'd15, 5'd12, 12'(($urandom % 128) * 4)));
        end
        prog.push_back(self_loop);
    endtask

    task automatic build_ctrl();
        prog = '{enc_ri12(op_addi_w, 5'd4, 5'd0, 12'd5),
                 enc_ri12(op_addi_w, 5'd5, 5'd0, 12'd5),
                 enc_ri12(op_addi_w, 5'd6, 5'd0, 12'd7),
                 enc_br(op_beq, 5'd4, 5'd5, 16'd2),                 // Taken
                 enc_ri12(op_addi_w, 5'd7, 5'd0, 12'd1),
                 enc_br(op_beq, 5'd4, 5'd6, 16'd2),
                 enc_ri12(op_addi_w, 5'd8, 5'd0, 12'd2),
                 enc_br(op_bne, 5'd4, 5'd6, 16'd2),                 // Taken
                 enc_ri12(op_addi_w, 5'd9, 5'd0, 12'd3),
                 enc_br(op_bne, 5'd4, 5'd5, 16'd2),
                 enc_ri12(op_addi_w, 5'd10, 5'd0, 12'd4),
                 enc_jump(op_b, 26'd3),                             // Skips two
                 enc_ri12(op_addi_w, 5'd11, 5'd0, 12'd9),
                 enc_ri12(op_addi_w, 5'd11, 5'd0, 12'd10),
                 enc_jump(op_bl, 26'd3),
                 enc_ri12(op_addi_w, 5'd12, 5'd0, 12'd11),
                 self_loop,
                 enc_ri12(op_addi_w, 5'd13, 5'd0, 12'd12),          // Subroutine
                 enc_br(op_jirl, 5'd1, 5'd0, 16'd0)};
    endtask

    task automatic build_dep();
        prog = '{enc_ri12(op_addi_w, 5'd4, 5'd0, 12'd3),
                 enc_3r(min_add_w, 5'd5, 5'd4, 5'd4),
                 enc_3r(min_add_w, 5'd6, 5'd5, 5'd4),
                 enc_3r(min_sub_w, 5'd7, 5'd6, 5'd5),
                 enc_ri12(op_addi_w, 5'd8, 5'd0, 12'h200),
                 enc_ri12(op_st_w, 5'd7, 5'd8, 12'd0),
                 enc_ri12(op_ld_w, 5'd9, 5'd8, 12'd0),
                 enc_3r(min_add_w, 5'd10, 5'd9, 5'd9),              // Load use
                 enc_ri12(op_addi_w, 5'd11, 5'd0, 12'd5),
                 enc_br(op_bne, 5'd11, 5'd0, 16'd2),
                 enc_ri12(op_addi_w, 5'd12, 5'd0, 12'd1),
                 enc_ri12(op_addi_w, 5'd13, 5'd10, 12'd1),
                 self_loop};
    endtask

    initial begin
        reset           = 1'b1;
        inst_sram_rdata = 32'd0;
        data_sram_rdata = 32'd0;
        got             = 0;
        test_errors     = 0;
        total_errors    = 0;
        failed_tests    = 0;
        test_count      = 0;
        void'($urandom(40));
        prog = '{enc_ri12(op_addi_w, 5'd4, 5'd0, 12'd1), self_loop};
        run_test("reset");
        build_alu();
        run_test("alu");
        build_shift();
        run_test("shift");
        build_mem();
        run_test("memory");
        build_ctrl();
        run_test("control");
        build_dep();
        run_test("depend");
        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, total_errors);
        if (total_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- src.f
+incdir+tb
design/cpu_pkg.sv
design/stage_link.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/cpu_top.sv
tb/tb_cpu_top.sv
